// ==== source/rename_defs.svh ====
`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// architectural register space
`define NUM_AREGS 32
`define AREG_W    5

// reorder buffer
`define ROB_DEPTH 64
`define ROB_ID_W  6

// datapath width
`define XLEN      32

// rename and retire slots per cycle
`define ISSUE_W   2

`endif

// ==== source/rename_pkg.sv ====
`include "rename_defs.svh"

package rename_pkg;

    typedef logic [`AREG_W-1:0]   areg_t;
    typedef logic [`ROB_ID_W-1:0] rob_id_t;

    // check bit flips on every rename of an areg
    typedef struct packed {
        logic    check;
        rob_id_t rob_id;
    } rat_entry_t;

    typedef enum logic [1:0] {
        FU_ALU    = 2'd0,
        FU_MDU    = 2'd1,
        FU_LSU    = 2'd2,
        FU_BRANCH = 2'd3
    } fu_op_e;

    typedef struct packed {
        logic              valid;
        fu_op_e            fu_op;
        areg_t [1:0]       src;
        areg_t             dst;
        logic              wr_reg;
        logic              use_imm;
        logic [`XLEN-1:0]  imm;
    } dec_slot_t;

    typedef struct packed {
        dec_slot_t [`ISSUE_W-1:0] slot;
        logic [`XLEN-1:0]         pc;
    } dec_pkt_t;

    typedef struct packed {
        logic                   valid;
        fu_op_e                 fu_op;
        areg_t                  dst;
        rob_id_t                dst_id;
        logic                   dst_check;
        rob_id_t [1:0]          src_id;
        logic [1:0][`XLEN-1:0]  src_data;
        logic [1:0]             src_rdy;
        logic                   use_imm;
        logic [`XLEN-1:0]       imm;
    } ren_slot_t;

    typedef struct packed {
        ren_slot_t [`ISSUE_W-1:0] slot;
        logic [`XLEN-1:0]         pc;
    } ren_pkt_t;

    typedef struct packed {
        logic             valid;
        logic             wr_reg;
        areg_t            areg;
        rob_id_t          rob_id;
        logic             check;
        logic [`XLEN-1:0] data;
    } retire_t;

    // r0 is hardwired and never committed
    function automatic logic retire_writes(retire_t r);
        return r.valid && r.wr_reg && (r.areg != '0);
    endfunction

endpackage

// ==== source/rob_alloc.sv ====
`timescale 1ns/1ps
`include "rename_defs.svh"

module rob_alloc import rename_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      flush_i,
    input  logic                      alloc_i,
    input  logic    [`ISSUE_W-1:0]    slot_valid_i,
    input  retire_t [`ISSUE_W-1:0]    retire_i,
    output rob_id_t [`ISSUE_W-1:0]    rob_id_o,
    output logic                      room_o
);

    localparam int CNT_W = `ROB_ID_W + 1;
    localparam int N_W   = $clog2(`ISSUE_W + 1);

    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] count_d;
    rob_id_t          ptr_q;
    rob_id_t          next_id;
    logic [N_W-1:0]   n_alloc;
    logic [N_W-1:0]   n_retire;

    // ids only go to valid slots starting at slot 0
    always_comb begin
        next_id  = ptr_q;
        n_alloc  = '0;
        n_retire = '0;
        for (int s = 0; s < `ISSUE_W; s++) begin
            rob_id_o[s] = next_id;
            if (slot_valid_i[s]) begin
                next_id = rob_id_t'(next_id + 1'b1);
                if (alloc_i) begin
                    n_alloc = N_W'(n_alloc + 1'b1);
                end
            end
            if (retire_i[s].valid) begin
                n_retire = N_W'(n_retire + 1'b1);
            end
        end
    end

    assign count_d = count_q + CNT_W'(n_alloc) - CNT_W'(n_retire);

    // room for a full pair
    assign room_o = (count_q <= CNT_W'(`ROB_DEPTH - `ISSUE_W));

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            count_q <= '0;
            ptr_q   <= '0;
        end else begin
            count_q <= count_d;
            if (alloc_i) begin
                ptr_q <= next_id;
            end
        end
    end

    a_count_bound: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        count_q <= CNT_W'(`ROB_DEPTH)
    );

    a_no_retire_empty: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (count_q == '0) |-> (n_retire == '0)
    );

endmodule

// ==== source/spec_rat.sv ====
`timescale 1ns/1ps
`include "rename_defs.svh"

module spec_rat import rename_pkg::*; (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic                             flush_i,
    input  areg_t      [2*`ISSUE_W-1:0]      raddr_i,
    output rat_entry_t [2*`ISSUE_W-1:0]      rdata_o,
    input  logic       [`ISSUE_W-1:0]        we_i,
    input  areg_t      [`ISSUE_W-1:0]        waddr_i,
    input  rat_entry_t [`ISSUE_W-1:0]        wdata_i,
    input  rat_entry_t [`NUM_AREGS-1:0]      snapshot_i
);

    rat_entry_t [`NUM_AREGS-1:0] table_q;

    always_comb begin
        for (int i = 0; i < 2*`ISSUE_W; i++) begin
            rdata_o[i] = table_q[raddr_i[i]];
        end
    end

    // later slot written last so it wins on a shared dst
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            table_q <= '0;
        end else if (flush_i) begin
            // roll back to committed state
            table_q <= snapshot_i;
        end else begin
            for (int s = 0; s < `ISSUE_W; s++) begin
                if (we_i[s]) begin
                    table_q[waddr_i[s]] <= wdata_i[s];
                end
            end
        end
    end

    // r0 is never renamed here and never committed upstream
    a_r0_unmapped: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        table_q[0] == '0
    );

endmodule

// ==== source/commit_rat.sv ====
`timescale 1ns/1ps
`include "rename_defs.svh"

module commit_rat import rename_pkg::*; (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  areg_t      [3*`ISSUE_W-1:0]      raddr_i,
    output rat_entry_t [3*`ISSUE_W-1:0]      rdata_o,
    input  retire_t    [`ISSUE_W-1:0]        retire_i,
    output rat_entry_t [`NUM_AREGS-1:0]      snapshot_o
);

    rat_entry_t [`NUM_AREGS-1:0] table_q;
    rat_entry_t [`NUM_AREGS-1:0] table_d;

    // retires come in rob order so slot 1 is younger
    always_comb begin
        table_d = table_q;
        for (int s = 0; s < `ISSUE_W; s++) begin
            if (retire_writes(retire_i[s])) begin
                table_d[retire_i[s].areg].check  = retire_i[s].check;
                table_d[retire_i[s].areg].rob_id = retire_i[s].rob_id;
            end
        end
    end

    // reads see this cycle's retires
    always_comb begin
        for (int i = 0; i < 3*`ISSUE_W; i++) begin
            rdata_o[i] = table_d[raddr_i[i]];
        end
    end

    // flush in the same cycle picks up the retires too
    assign snapshot_o = table_d;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            table_q <= '0;
        end else begin
            table_q <= table_d;
        end
    end

endmodule

// ==== source/arch_regfile.sv ====
`timescale 1ns/1ps
`include "rename_defs.svh"

module arch_regfile import rename_pkg::*; (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  areg_t [2*`ISSUE_W-1:0]              raddr_i,
    output logic  [2*`ISSUE_W-1:0][`XLEN-1:0]   rdata_o,
    input  retire_t [`ISSUE_W-1:0]              retire_i
);

    logic [`NUM_AREGS-1:0][`XLEN-1:0] rf_q;
    logic [`NUM_AREGS-1:0][`XLEN-1:0] rf_d;

    always_comb begin
        rf_d = rf_q;
        for (int s = 0; s < `ISSUE_W; s++) begin
            if (retire_writes(retire_i[s])) begin
                rf_d[retire_i[s].areg] = retire_i[s].data;
            end
        end
    end

    // write-to-read bypass
    always_comb begin
        for (int i = 0; i < 2*`ISSUE_W; i++) begin
            rdata_o[i] = rf_d[raddr_i[i]];
        end
    end

    // committed state survives a flush
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rf_q <= '0;
        end else begin
            rf_q <= rf_d;
        end
    end

endmodule

// ==== source/rename_stage.sv ====
`timescale 1ns/1ps
`include "rename_defs.svh"

module rename_stage import rename_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     flush_i,
    input  logic                     dec_valid_i,
    input  dec_pkt_t                 dec_pkt_i,
    output logic                     dec_ready_o,
    output logic                     ren_valid_o,
    output ren_pkt_t                 ren_pkt_o,
    input  logic                     ren_ready_i,
    input  retire_t [`ISSUE_W-1:0]   retire_i
);

    localparam int NUM_SRC = 2 * `ISSUE_W;

    logic                                   accept;
    logic                                   room;
    rob_id_t    [`ISSUE_W-1:0]              alloc_id;
    logic       [`ISSUE_W-1:0]              slot_valid;
    logic       [`ISSUE_W-1:0]              dst_wr;
    logic       [`ISSUE_W-1:0]              rat_we;
    areg_t      [`ISSUE_W-1:0]              rat_waddr;
    rat_entry_t [`ISSUE_W-1:0]              new_entry;
    areg_t      [NUM_SRC-1:0]               src_areg;
    logic       [NUM_SRC-1:0]               src_byp;
    logic       [NUM_SRC-1:0]               src_used;
    rat_entry_t [NUM_SRC-1:0]               spec_rdata;
    areg_t      [NUM_SRC+`ISSUE_W-1:0]      cmt_raddr;
    rat_entry_t [NUM_SRC+`ISSUE_W-1:0]      cmt_rdata;
    rat_entry_t [`NUM_AREGS-1:0]            cmt_snapshot;
    logic       [NUM_SRC-1:0][`XLEN-1:0]    rf_rdata;
    ren_pkt_t                               pkt_d;

    assign dec_ready_o = room && !flush_i && (!ren_valid_o || ren_ready_i);
    assign accept      = dec_valid_i && dec_ready_o;

    // dst lookups sit above the sources
    assign cmt_raddr = {rat_waddr, src_areg};

    always_comb begin
        for (int s = 0; s < `ISSUE_W; s++) begin
            slot_valid[s] = dec_pkt_i.slot[s].valid;
            dst_wr[s]     = dec_pkt_i.slot[s].valid && dec_pkt_i.slot[s].wr_reg &&
                            (dec_pkt_i.slot[s].dst != '0);
            rat_we[s]     = accept && dst_wr[s];
            rat_waddr[s]  = dec_pkt_i.slot[s].dst;
            new_entry[s].check  = ~cmt_rdata[NUM_SRC + s].check;
            new_entry[s].rob_id = alloc_id[s];
            for (int k = 0; k < 2; k++) begin
                src_areg[2*s + k] = dec_pkt_i.slot[s].src[k];
                // immediate replaces the second operand
                src_used[2*s + k] = !(k == 1 && dec_pkt_i.slot[s].use_imm);
                // slot 1 depends on slot 0 in the same pair
                src_byp[2*s + k]  = (s != 0) && dst_wr[0] &&
                                    (dec_pkt_i.slot[s].src[k] == rat_waddr[0]);
            end
        end
    end

    always_comb begin
        pkt_d.pc = dec_pkt_i.pc;
        for (int s = 0; s < `ISSUE_W; s++) begin
            pkt_d.slot[s].valid     = dec_pkt_i.slot[s].valid;
            pkt_d.slot[s].fu_op     = dec_pkt_i.slot[s].fu_op;
            pkt_d.slot[s].dst       = dec_pkt_i.slot[s].dst;
            pkt_d.slot[s].dst_id    = new_entry[s].rob_id;
            pkt_d.slot[s].dst_check = new_entry[s].check;
            pkt_d.slot[s].use_imm   = dec_pkt_i.slot[s].use_imm;
            pkt_d.slot[s].imm       = dec_pkt_i.slot[s].imm;
            for (int k = 0; k < 2; k++) begin
                pkt_d.slot[s].src_id[k]   = src_byp[2*s + k] ? new_entry[0].rob_id :
                                            spec_rdata[2*s + k].rob_id;
                pkt_d.slot[s].src_data[k] = rf_rdata[2*s + k];
                // committed when spec and commit mappings agree
                pkt_d.slot[s].src_rdy[k]  = !src_byp[2*s + k] &&
                                            ((src_areg[2*s + k] == '0) ||
                                             (spec_rdata[2*s + k] == cmt_rdata[2*s + k]) ||
                                             !src_used[2*s + k]);
            end
        end
    end

    rob_alloc i_rob_alloc (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .alloc_i      (accept),
        .slot_valid_i (slot_valid),
        .retire_i     (retire_i),
        .rob_id_o     (alloc_id),
        .room_o       (room)
    );

    spec_rat i_spec_rat (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .flush_i    (flush_i),
        .raddr_i    (src_areg),
        .rdata_o    (spec_rdata),
        .we_i       (rat_we),
        .waddr_i    (rat_waddr),
        .wdata_i    (new_entry),
        .snapshot_i (cmt_snapshot)
    );

    commit_rat i_commit_rat (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .raddr_i    (cmt_raddr),
        .rdata_o    (cmt_rdata),
        .retire_i   (retire_i),
        .snapshot_o (cmt_snapshot)
    );

    arch_regfile i_arch_regfile (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .raddr_i  (src_areg),
        .rdata_o  (rf_rdata),
        .retire_i (retire_i)
    );

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            ren_valid_o <= 1'b0;
        end else if (accept) begin
            ren_valid_o <= 1'b1;
        end else if (ren_ready_i) begin
            ren_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ren_pkt_o <= pkt_d;
        end
    end

    // dispatch side must see a stalled packet unchanged
    a_out_stable: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (ren_valid_o && !ren_ready_i && !flush_i) |=> (ren_valid_o && $stable(ren_pkt_o))
    );

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release just after an edge like every other input
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #2 rst_n_o = 1'b1;
    end

endmodule

// ==== sim/rename_tb.sv ====
`timescale 1ns/1ps
`include "rename_defs.svh"

module rename_tb import rename_pkg::*; ();

    localparam int B_RESET  = 10;
    localparam int B_DEP    = 20;
    localparam int B_PAIR   = 12;
    localparam int B_RETIRE = 200;
    localparam int B_BP     = 60;
    localparam int B_FILL   = 40;
    localparam int B_DRAIN  = 80;
    localparam int B_FLUSH  = 80;
    localparam int TIMEOUT_CYCLES = 2 * (B_RESET + B_DEP + B_PAIR + B_RETIRE +
                                         B_BP + B_FILL + B_DRAIN + B_FLUSH);

    logic                    clk;
    logic                    rst_n;
    logic                    flush;
    logic                    dec_valid;
    dec_pkt_t                dec_pkt;
    logic                    dec_ready;
    logic                    ren_valid;
    ren_pkt_t                ren_pkt;
    logic                    ren_ready;
    retire_t [`ISSUE_W-1:0]  retire;

    // reference model state
    rat_entry_t       m_spec [`NUM_AREGS];
    rat_entry_t       m_cmt  [`NUM_AREGS];
    logic [`XLEN-1:0] m_rf   [`NUM_AREGS];
    int               m_count;
    rob_id_t          m_ptr;
    logic             m_valid;
    ren_pkt_t         exp_q  [$];
    retire_t          pend_q [$];

    logic [31:0] lfsr;
    logic        last_accept;
    int          reg_bits;
    logic        knob_ret;
    logic        knob_bp;
    logic        knob_dec;
    int          room_low_cnt;
    int          errors;
    int          checks;
    int          n_tests;
    int          err_base;
    int          cycle_cnt = 0;

    tb_clock_gen #(.PERIOD_NS(40), .RST_CYCLES(10)) i_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    rename_stage i_dut (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .flush_i     (flush),
        .dec_valid_i (dec_valid),
        .dec_pkt_i   (dec_pkt),
        .dec_ready_o (dec_ready),
        .ren_valid_o (ren_valid),
        .ren_pkt_o   (ren_pkt),
        .ren_ready_i (ren_ready),
        .retire_i    (retire)
    );

    // galois lfsr on x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic dec_pkt_t rand_pkt();
        dec_pkt_t p;
        p.pc = rand_bits(32);
        for (int s = 0; s < `ISSUE_W; s++) begin
            p.slot[s].valid   = (rand_bits(3) != 0);
            p.slot[s].fu_op   = fu_op_e'(2'(rand_bits(2)));
            p.slot[s].src[0]  = areg_t'(rand_bits(reg_bits));
            p.slot[s].src[1]  = areg_t'(rand_bits(reg_bits));
            p.slot[s].dst     = areg_t'(rand_bits(reg_bits));
            p.slot[s].wr_reg  = (rand_bits(2) != 0);
            p.slot[s].use_imm = (rand_bits(1) != 0);
            p.slot[s].imm     = rand_bits(32);
        end
        return p;
    endfunction

    task automatic check_ready(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error @%0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic field_error(input string what, input int slot,
                               input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp);
        errors++;
        $display("error @%0t: slot %0d %s is %h, expected %h", $time, slot, what, got, exp);
    endtask

    task automatic check_pkt(input ren_pkt_t got, input ren_pkt_t exp);
        checks++;
        if (got.pc !== exp.pc) begin
            errors++;
            $display("error @%0t: pc is %h, expected %h", $time, got.pc, exp.pc);
        end
        for (int s = 0; s < `ISSUE_W; s++) begin
            if (got.slot[s].valid !== exp.slot[s].valid)
                field_error("valid", s, got.slot[s].valid, exp.slot[s].valid);
            if (exp.slot[s].valid) begin
                if (got.slot[s].fu_op !== exp.slot[s].fu_op)
                    field_error("fu_op", s, got.slot[s].fu_op, exp.slot[s].fu_op);
                if (got.slot[s].dst !== exp.slot[s].dst)
                    field_error("dst", s, got.slot[s].dst, exp.slot[s].dst);
                if (got.slot[s].dst_id !== exp.slot[s].dst_id)
                    field_error("dst_id", s, got.slot[s].dst_id, exp.slot[s].dst_id);
                if (got.slot[s].dst_check !== exp.slot[s].dst_check)
                    field_error("dst_check", s, got.slot[s].dst_check, exp.slot[s].dst_check);
                if (got.slot[s].use_imm !== exp.slot[s].use_imm)
                    field_error("use_imm", s, got.slot[s].use_imm, exp.slot[s].use_imm);
                if (got.slot[s].imm !== exp.slot[s].imm)
                    field_error("imm", s, got.slot[s].imm, exp.slot[s].imm);
                for (int k = 0; k < 2; k++) begin
                    if (got.slot[s].src_id[k] !== exp.slot[s].src_id[k])
                        field_error("src_id", s, got.slot[s].src_id[k], exp.slot[s].src_id[k]);
                    if (got.slot[s].src_data[k] !== exp.slot[s].src_data[k])
                        field_error("src_data", s, got.slot[s].src_data[k],
                                    exp.slot[s].src_data[k]);
                    if (got.slot[s].src_rdy[k] !== exp.slot[s].src_rdy[k])
                        field_error("src_rdy", s, got.slot[s].src_rdy[k], exp.slot[s].src_rdy[k]);
                end
            end
        end
    endtask

    // checks this cycle and advances the model to the next edge
    task automatic model_step();
        rat_entry_t       cmt_f [`NUM_AREGS];
        logic [`XLEN-1:0] rf_f  [`NUM_AREGS];
        ren_pkt_t         exp_pkt;
        retire_t          r;
        rob_id_t          ids [`ISSUE_W];
        rob_id_t          nid;
        logic [`ISSUE_W-1:0] dst_wr;
        logic [`ISSUE_W-1:0] chk;
        logic             exp_ready;
        logic             byp;
        areg_t            a;
        int               n_ret;
        #1;
        cmt_f = m_cmt;
        rf_f  = m_rf;
        n_ret = 0;
        // retires are visible to readers in the same cycle
        for (int s = 0; s < `ISSUE_W; s++) begin
            if (retire[s].valid)
                n_ret++;
            if (retire[s].valid && retire[s].wr_reg && retire[s].areg != 0) begin
                cmt_f[retire[s].areg].check  = retire[s].check;
                cmt_f[retire[s].areg].rob_id = retire[s].rob_id;
                rf_f[retire[s].areg]         = retire[s].data;
            end
        end
        exp_ready = (m_count <= `ROB_DEPTH - `ISSUE_W) && !flush && (!m_valid || ren_ready);
        check_ready(dec_ready, exp_ready, "dec_ready_o");
        check_ready(ren_valid, m_valid, "ren_valid_o");
        if (m_count > `ROB_DEPTH - `ISSUE_W)
            room_low_cnt++;
        if (m_valid && ren_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("dispatch took a packet although none was outstanding");
            end else begin
                check_pkt(ren_pkt, exp_q.pop_front());
            end
        end
        last_accept = dec_valid && exp_ready;
        nid = m_ptr;
        for (int s = 0; s < `ISSUE_W; s++) begin
            ids[s]    = nid;
            if (dec_pkt.slot[s].valid)
                nid++;
            dst_wr[s] = dec_pkt.slot[s].valid && dec_pkt.slot[s].wr_reg &&
                        (dec_pkt.slot[s].dst != 0);
            chk[s]    = ~cmt_f[dec_pkt.slot[s].dst].check;
        end
        if (last_accept) begin
            exp_pkt.pc = dec_pkt.pc;
            for (int s = 0; s < `ISSUE_W; s++) begin
                exp_pkt.slot[s].valid     = dec_pkt.slot[s].valid;
                exp_pkt.slot[s].fu_op     = dec_pkt.slot[s].fu_op;
                exp_pkt.slot[s].dst       = dec_pkt.slot[s].dst;
                exp_pkt.slot[s].dst_id    = ids[s];
                exp_pkt.slot[s].dst_check = chk[s];
                exp_pkt.slot[s].use_imm   = dec_pkt.slot[s].use_imm;
                exp_pkt.slot[s].imm       = dec_pkt.slot[s].imm;
                for (int k = 0; k < 2; k++) begin
                    a   = dec_pkt.slot[s].src[k];
                    byp = (s == 1) && dst_wr[0] && (a == dec_pkt.slot[0].dst);
                    exp_pkt.slot[s].src_id[k]   = byp ? ids[0] : m_spec[a].rob_id;
                    exp_pkt.slot[s].src_data[k] = rf_f[a];
                    exp_pkt.slot[s].src_rdy[k]  = !byp && ((a == 0) || (m_spec[a] == cmt_f[a]) ||
                                                  (k == 1 && dec_pkt.slot[s].use_imm));
                end
                if (dec_pkt.slot[s].valid) begin
                    r        = '0;
                    r.valid  = 1'b1;
                    r.wr_reg = dec_pkt.slot[s].wr_reg;
                    r.areg   = dec_pkt.slot[s].dst;
                    r.rob_id = ids[s];
                    r.check  = chk[s];
                    pend_q.push_back(r);
                end
            end
            exp_q.push_back(exp_pkt);
        end
        m_cmt = cmt_f;
        m_rf  = rf_f;
        if (flush) begin
            m_spec  = cmt_f;
            m_count = 0;
            m_ptr   = '0;
            m_valid = 1'b0;
            exp_q.delete();
            pend_q.delete();
        end else begin
            m_count = m_count - n_ret;
            if (last_accept) begin
                m_ptr = nid;
                for (int s = 0; s < `ISSUE_W; s++) begin
                    if (dec_pkt.slot[s].valid)
                        m_count++;
                    if (dst_wr[s]) begin
                        m_spec[dec_pkt.slot[s].dst].check  = chk[s];
                        m_spec[dec_pkt.slot[s].dst].rob_id = ids[s];
                    end
                end
                m_valid = 1'b1;
            end else if (ren_ready) begin
                m_valid = 1'b0;
            end
        end
        @(posedge clk);
        #2;
    endtask

    // retires pop the oldest renamed instructions in order
    task automatic one_cycle();
        retire_t r;
        logic    go;
        ren_ready = knob_bp ? (rand_bits(1) != 0) : 1'b1;
        go = knob_ret;
        for (int s = 0; s < `ISSUE_W; s++) begin
            r = '0;
            if (go && pend_q.size() > 0 && rand_bits(1) != 0) begin
                r      = pend_q.pop_front();
                r.data = rand_bits(32);
            end else begin
                go = 1'b0;
            end
            retire[s] = r;
        end
        model_step();
    endtask

    task automatic random_cycles(input int n);
        repeat (n) begin
            // a stalled packet is held
            if (!dec_valid || last_accept) begin
                dec_valid = knob_dec ? 1'b1 : (rand_bits(3) == 0);
                dec_pkt   = rand_pkt();
            end
            one_cycle();
        end
    endtask

    task automatic send_pkt(input dec_pkt_t p);
        dec_valid = 1'b1;
        dec_pkt   = p;
        do begin
            one_cycle();
        end while (!last_accept);
        dec_valid = 1'b0;
    endtask

    task automatic do_flush();
        dec_valid = 1'b0;
        flush     = 1'b1;
        one_cycle();
        flush     = 1'b0;
    endtask

    task automatic report_test(input string name);
        n_tests++;
        $display("test %0d %s: %0d errors", n_tests, name, errors - err_base);
        err_base = errors;
    endtask

    initial begin
        dec_pkt_t p;
        flush     = 1'b0;
        dec_valid = 1'b0;
        dec_pkt   = '0;
        ren_ready = 1'b1;
        retire    = '0;
        lfsr      = 32'd9272;
        for (int i = 0; i < `NUM_AREGS; i++) begin
            m_spec[i] = '0;
            m_cmt[i]  = '0;
            m_rf[i]   = '0;
        end
        m_count      = 0;
        m_ptr        = '0;
        m_valid      = 1'b0;
        last_accept  = 1'b0;
        room_low_cnt = 0;
        errors       = 0;
        checks       = 0;
        n_tests      = 0;
        err_base     = 0;
        knob_ret     = 1'b0;
        knob_bp      = 1'b0;
        knob_dec     = 1'b1;
        reg_bits     = 5;
        @(posedge rst_n);

        random_cycles(B_RESET);
        report_test("rename after reset");

        reg_bits = 3;
        random_cycles(B_DEP);
        report_test("pending sources");

        knob_ret = 1'b1;
        p = rand_pkt();
        p.slot[0].valid   = 1'b1;
        p.slot[0].wr_reg  = 1'b1;
        p.slot[0].dst     = 5'd5;
        p.slot[1].valid   = 1'b1;
        p.slot[1].src[0]  = 5'd5;
        p.slot[1].src[1]  = 5'd5;
        p.slot[1].use_imm = 1'b0;
        send_pkt(p);
        // both slots rename r6 and slot 1 keeps the mapping
        p = rand_pkt();
        p.slot[0].valid   = 1'b1;
        p.slot[0].wr_reg  = 1'b1;
        p.slot[0].dst     = 5'd6;
        p.slot[1].valid   = 1'b1;
        p.slot[1].wr_reg  = 1'b1;
        p.slot[1].dst     = 5'd6;
        send_pkt(p);
        p = rand_pkt();
        p.slot[0].valid   = 1'b1;
        p.slot[0].src[0]  = 5'd6;
        p.slot[0].src[1]  = 5'd5;
        p.slot[0].use_imm = 1'b0;
        send_pkt(p);
        random_cycles(6);
        report_test("intra-pair dependency");

        // sparse decode lets the ROB drain so latest writers retire
        knob_dec = 1'b0;
        random_cycles(B_RETIRE);
        knob_dec = 1'b1;
        report_test("retire and forwarding");

        knob_bp = 1'b1;
        random_cycles(B_BP);
        knob_bp      = 1'b0;
        knob_ret     = 1'b0;
        room_low_cnt = 0;
        random_cycles(B_FILL);
        if (room_low_cnt == 0) begin
            errors++;
            $display("the ROB never filled up during the fill phase");
        end
        knob_ret = 1'b1;
        random_cycles(B_DRAIN);
        report_test("back-pressure and full ROB");

        do_flush();
        random_cycles(B_FLUSH - 1);
        report_test("flush");

        $display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

endmodule

// ==== build.f ====
+incdir+source
source/rename_pkg.sv
source/rob_alloc.sv
source/spec_rat.sv
source/commit_rat.sv
source/arch_regfile.sv
source/rename_stage.sv
sim/tb_clock_gen.sv
sim/rename_tb.sv

// ==== Bender.yml ====
package:
  name: rename_stage

sources:
  - include_dirs:
      - source
    files:
      - source/rename_pkg.sv
      - source/rob_alloc.sv
      - source/spec_rat.sv
      - source/commit_rat.sv
      - source/arch_regfile.sv
      - source/rename_stage.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/tb_clock_gen.sv
      - sim/rename_tb.sv
